// File: filelist.f
hw/cam_pkg.sv
hw/cam_input_conditioner.sv
hw/line_tracker.sv
hw/interleave_sequencer.sv
hw/capture_fsm.sv
hw/camera_capture_top.sv
verification/camera_capture_assertions.sv
verification/camera_capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for a reported failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns --top-module camera_capture_tb \
    -f filelist.f -o camera_capture_sim > build.log 2>&1 || { cat build.log; exit 1; }
status=0
./obj_dir/camera_capture_sim > sim.log 2>&1 || status=1
cat sim.log
grep -q "Testbench failed" sim.log && status=1
[ "$status" -eq 0 ] && echo "Simulation run is clean" || echo "Simulation run has errors"
exit "$status"

// File: verification/camera_capture_trace.txt
// Camera capture trace, one hex word per line
// Words 0 to 5 set up the camera model, the rest is the expected kept line order
c    // frames generated by the camera model
2    // blanking pixels before each line, random extra pixels are added
6    // blanking pixels in the gap between frames
200  // clocks from sensor reset release to the first request
100  // clocks from image_finished to the second request
c    // kept lines per capture
0
1
8    // first jump
2
3
a
4
5
9    // wrap-around fill of the cut-off pair
6
7
b

// File: verification/camera_capture_tb.sv
`timescale 1ns/1ns

module camera_capture_tb;

    import cam_pkg::*;

    // Single-clock disturbance the camera model may add to a pixel
    typedef enum int {
        no_glitch,
        line_valid_glitch,
        pixel_bit_glitch
    } glitch_t;

    logic clk;
    logic rst_n;
    logic pixel_clock;
    logic frame_valid;
    logic line_valid;
    logic [pixel_width-1:0] pixel_in;
    logic request_image;
    logic camera_reset_n;
    logic image_started;
    logic image_finished;
    logic sample_pixel_pulse;
    logic keep_pixel;
    logic [fifo_width-1:0] data_for_fifo;

    // Six camera model words, then the kept line order
    logic [31:0] trace_mem [0:17];
    int n_frames;
    int line_blank;
    int frame_blank;
    int first_request_delay;
    int second_request_delay;
    int n_kept_lines;
    logic [7:0] lfsr_state;
    // High while the camera model drives the gap between frames
    logic in_frame_gap;
    // Bytes the FIFO would store during the current capture
    logic [fifo_width-1:0] kept_bytes [$];

    camera_capture_top i_camera_capture_top (
        .clk(clk),
        .rst_n(rst_n),
        .pixel_clock(pixel_clock),
        .frame_valid(frame_valid),
        .line_valid(line_valid),
        .pixel_in(pixel_in),
        .request_image(request_image),
        .camera_reset_n(camera_reset_n),
        .image_started(image_started),
        .image_finished(image_finished),
        .sample_pixel_pulse(sample_pixel_pulse),
        .keep_pixel(keep_pixel),
        .data_for_fifo(data_for_fifo)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // ************************************************************************
    // Checks
    // ************************************************************************

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_byte(input string name, input logic [fifo_width-1:0] actual,
                                input logic [fifo_width-1:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    task automatic compare_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    task automatic compare_count(input string name, input count_t actual, input count_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                     name, actual, expected));
        end
    endtask

    // ************************************************************************
    // Camera model
    // ************************************************************************

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Line in the top nibble, column below it, a constant nibble at the bottom
    function automatic logic [pixel_width-1:0] pixel_value(input int row, input int col);
        return {4'(row), 4'(col), 4'hF};
    endfunction

    // The FIFO gets the upper byte of the pixel, so line and column nibbles
    function automatic logic [fifo_width-1:0] expected_byte(input int row, input int col);
        return {4'(row), 4'(col)};
    endfunction

    // One pixel-clock period of eight system clocks
    task automatic drive_pixel(input logic fv, input logic lv,
                               input logic [pixel_width-1:0] data, input glitch_t glitch);
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            // Data changes together with the pixel-clock rise
            pixel_clock = (c < 4);
            frame_valid = fv;
            line_valid = lv;
            pixel_in = data;
            if (glitch == line_valid_glitch && c == 2) begin
                line_valid = ~lv;
            end
            // Two clocks after the pixel-clock fall, exactly where the DUT samples
            if (glitch == pixel_bit_glitch && c == 6) begin
                pixel_in[pixel_width-2] = ~data[pixel_width-2];
            end
        end
    endtask

    task automatic drive_frame();
        int extra;
        glitch_t glitch;
        in_frame_gap = 1'b0;
        for (int row = 0; row < lines_in_frame; row++) begin
            // Two LFSR bits add zero to three blanking pixels
            random_bits(2, extra);
            for (int b = 0; b < line_blank + extra; b++) begin
                glitch = (row == 3 && b == 1) ? line_valid_glitch : no_glitch;
                drive_pixel(1'b1, 1'b0, '0, glitch);
            end
            for (int col = 0; col < valid_line_size; col++) begin
                glitch = (row == 5 && col == 2) ? pixel_bit_glitch : no_glitch;
                drive_pixel(1'b1, 1'b1, pixel_value(row, col), glitch);
            end
        end
        // Blanking after the last line, frame valid still high
        for (int b = 0; b < line_blank; b++) begin
            drive_pixel(1'b1, 1'b0, '0, no_glitch);
        end
        in_frame_gap = 1'b1;
        for (int b = 0; b < frame_blank; b++) begin
            drive_pixel(1'b0, 1'b0, '0, no_glitch);
        end
    endtask

    initial begin
        int cycles;
        cycles = 0;
        // The sensor stays silent while it is held in reset
        while (camera_reset_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 4 * boot_settle_cycles) begin
                report_failure("The camera model never saw its reset released");
            end
        end
        for (int f = 0; f < n_frames; f++) begin
            drive_frame();
        end
    end

    // Collects every byte that the FIFO would store
    initial begin
        forever begin
            @(negedge clk);
            if (sample_pixel_pulse === 1'b1 && keep_pixel === 1'b1) begin
                kept_bytes.push_back(data_for_fifo);
            end
        end
    end

    // ************************************************************************
    // Capture sequence
    // ************************************************************************

    task automatic run_capture(input int request_delay);
        int cycles;
        int row;
        kept_bytes.delete();
        for (int i = 0; i < request_delay; i++) begin
            @(negedge clk);
            compare_flag("image_started", image_started, 1'b0);
            compare_flag("image_finished", image_finished, 1'b1);
            compare_flag("camera_reset_n", camera_reset_n, 1'b1);
        end
        request_image = 1'b1;
        @(negedge clk);
        request_image = 1'b0;

        cycles = 0;
        while (image_started !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > state_timeout_cycles) begin
                report_failure("image_started did not rise after request_image");
            end
        end
        // Streaming may only begin in a gap between frames
        if (!in_frame_gap) begin
            report_failure("image_started rose while the camera was inside a frame");
        end

        cycles = 0;
        while (image_started === 1'b1) begin
            compare_flag("image_finished", image_finished, 1'b0);
            compare_flag("camera_reset_n", camera_reset_n, 1'b1);
            @(negedge clk);
            cycles++;
            if (cycles > state_timeout_cycles) begin
                report_failure("image_started did not fall after the last kept line");
            end
        end
        compare_flag("image_finished", image_finished, 1'b1);

        // Groups of valid_line_size bytes, in trace line order, columns ascending
        compare_count("kept byte count", count_t'(kept_bytes.size()),
                      count_t'(n_kept_lines * valid_line_size));
        for (int k = 0; k < n_kept_lines; k++) begin
            row = int'(trace_mem[6 + k]);
            for (int col = 0; col < valid_line_size; col++) begin
                compare_byte("data_for_fifo", kept_bytes[k * valid_line_size + col],
                             expected_byte(row, col));
            end
        end
    endtask

    initial begin
        int cycles;
        rst_n = 1'b0;
        pixel_clock = 1'b0;
        frame_valid = 1'b0;
        line_valid = 1'b0;
        pixel_in = '0;
        request_image = 1'b0;
        in_frame_gap = 1'b1;
        lfsr_state = 8'd60;
        // Every word starts out holding its own address, so a short file shows up
        foreach (trace_mem[i]) begin
            trace_mem[i] = {16'hFFFF, 16'(i)};
        end
        $readmemh("verification/camera_capture_trace.txt", trace_mem);
        if (trace_mem[17] === {16'hFFFF, 16'd17}) begin
            report_failure("The trace file could not be read completely");
        end
        n_frames = int'(trace_mem[0]);
        line_blank = int'(trace_mem[1]);
        frame_blank = int'(trace_mem[2]);
        first_request_delay = int'(trace_mem[3]);
        second_request_delay = int'(trace_mem[4]);
        n_kept_lines = int'(trace_mem[5]);

        repeat (5) @(negedge clk);
        compare_flag("camera_reset_n", camera_reset_n, 1'b0);
        compare_flag("keep_pixel", keep_pixel, 1'b0);
        compare_flag("image_started", image_started, 1'b0);
        rst_n = 1'b1;

        // Sensor reset is released once, a fixed boot time after reset
        cycles = 0;
        while (camera_reset_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 4 * boot_settle_cycles) begin
                report_failure("camera_reset_n never rose after reset");
            end
        end
        compare_count("camera_reset_n delay", count_t'(cycles), count_t'(boot_settle_cycles));
        compare_flag("sample_pixel_pulse", sample_pixel_pulse, 1'b0);

        run_capture(first_request_delay);
        // The second capture has to repeat the first one exactly
        run_capture(second_request_delay);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verification/camera_capture_assertions.sv
`timescale 1ns/1ns

module camera_capture_assertions (
    input logic clk,
    input logic rst_n,
    input logic camera_reset_n,
    input logic image_started,
    input logic keep_pixel,
    input logic sample_pixel_pulse
);

    // The FIFO may only be written while an image is being captured
    keep_implies_started: assert property (
        @(posedge clk) disable iff (!rst_n) keep_pixel |-> image_started
    ) else $error("keep_pixel is high while image_started is low");

    // The sample strobe comes from a single edge and is one clock wide
    strobe_single_clock: assert property (
        @(posedge clk) disable iff (!rst_n) sample_pixel_pulse |=> !sample_pixel_pulse
    ) else $error("sample_pixel_pulse stayed high for two clocks");

    // Sensor reset is a register, so it follows rst_n one clock later
    sensor_held_in_reset: assert property (
        @(posedge clk) !rst_n |=> !camera_reset_n
    ) else $error("camera_reset_n is high while the DUT is in reset");

endmodule

bind camera_capture_top camera_capture_assertions i_camera_capture_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .camera_reset_n(camera_reset_n),
    .image_started(image_started),
    .keep_pixel(keep_pixel),
    .sample_pixel_pulse(sample_pixel_pulse)
);

// File: hw/camera_capture_top.sv
`timescale 1ns/1ns

module camera_capture_top (
    input logic clk,
    input logic rst_n,
    input logic pixel_clock,
    input logic frame_valid,
    input logic line_valid,
    input logic [cam_pkg::pixel_width-1:0] pixel_in,
    input logic request_image,
    output logic camera_reset_n,
    output logic image_started,
    output logic image_finished,
    output logic sample_pixel_pulse,
    output logic keep_pixel,
    output logic [cam_pkg::fifo_width-1:0] data_for_fifo
);

    import cam_pkg::*;

    // Camera inputs gathered into one bus so they stay aligned
    cam_bus_t raw_bus;
    cam_bus_t filtered;
    cam_events_t events;
    line_pos_t pos;
    logic streaming;
    logic all_frames_done;

    assign raw_bus = '{
        pixclk: pixel_clock,
        frame_valid: frame_valid,
        line_valid: line_valid,
        pixel: pixel_in
    };

    cam_input_conditioner i_cam_input_conditioner (
        .clk(clk),
        .raw(raw_bus),
        .filtered(filtered),
        .events(events)
    );

    line_tracker i_line_tracker (
        .clk(clk),
        .rst_n(rst_n),
        .filtered(filtered),
        .events(events),
        .pos(pos)
    );

    interleave_sequencer i_interleave_sequencer (
        .clk(clk),
        .rst_n(rst_n),
        .pos(pos),
        .streaming(streaming),
        .all_frames_done(all_frames_done),
        .keep_pixel(keep_pixel)
    );

    capture_fsm i_capture_fsm (
        .clk(clk),
        .rst_n(rst_n),
        .events(events),
        .request_image(request_image),
        .all_frames_done(all_frames_done),
        .camera_reset_n(camera_reset_n),
        .streaming(streaming)
    );

    assign image_started = streaming;
    assign image_finished = ~streaming;
    assign sample_pixel_pulse = events.sample_strobe;
    // Only the upper bits of each pixel go into the FIFO
    assign data_for_fifo = filtered.pixel[pixel_width-1 -: fifo_width];

endmodule

// File: hw/capture_fsm.sv
`timescale 1ns/1ns

module capture_fsm (
    input logic clk,
    input logic rst_n,
    input cam_pkg::cam_events_t events,
    input logic request_image,
    input logic all_frames_done,
    output logic camera_reset_n,
    output logic streaming
);

    import cam_pkg::*;

    // ************************************************************************
    // Capture state machine
    // ************************************************************************

    capture_state_t state;
    // Clocks spent in the current state, cleared on every transition
    state_timer_t state_timer;
    logic timed_out;

    // Last guard against a hang
    // Only the waiting and streaming states can overrun
    assign timed_out = (state_timer > state_timer_t'(state_timeout_cycles))
                     && (state != BOOT)
                     && (state != IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= BOOT;
            state_timer <= '0;
            camera_reset_n <= 1'b0;
        end else if (timed_out) begin
            state <= BOOT;
            state_timer <= '0;
        end else begin
            state_timer <= state_timer + state_timer_t'(1);
            case (state)
                BOOT: begin
                    // The sensor stays in reset while things settle
                    camera_reset_n <= 1'b0;
                    if (state_timer >= state_timer_t'(boot_settle_cycles - 1)) begin
                        camera_reset_n <= 1'b1;
                        state <= IDLE;
                        state_timer <= '0;
                    end
                end
                IDLE: begin
                    if (request_image) begin
                        state <= WAIT_FRAME_END;
                        state_timer <= '0;
                    end
                end
                WAIT_FRAME_END: begin
                    // Streaming may only begin in an inter-frame gap
                    // The trackers then come up before the next frame starts
                    if (events.out_of_frame) begin
                        state <= STREAMING;
                        state_timer <= '0;
                    end
                end
                STREAMING: begin
                    // Bytes flow until every interleaved frame is captured
                    if (all_frames_done) begin
                        state <= IDLE;
                        state_timer <= '0;
                    end
                end
                default: begin
                    state <= BOOT;
                    state_timer <= '0;
                end
            endcase
        end
    end

    assign streaming = (state == STREAMING);

endmodule

// File: hw/interleave_sequencer.sv
`timescale 1ns/1ns

module interleave_sequencer (
    input logic clk,
    input logic rst_n,
    input cam_pkg::line_pos_t pos,
    input logic streaming,
    output logic all_frames_done,
    output logic keep_pixel
);

    import cam_pkg::*;

    // ************************************************************************
    // Bayer-preserving interleave
    // ************************************************************************

    // The target line is held three times and voted bit by bit
    // A single upset in one copy cannot send the sequencer to a line that
    // never comes
    count_t target_copy [0:2];
    count_t voted_target;
    // Step taken after a line of the current interleaved frame is kept
    count_t next_target;
    // First line of the following interleaved frame
    count_t restart_target;
    // Line index inside the current interleaved frame
    count_t line_in_iframe;
    frame_idx_t frame_idx;
    logic target_done;

    assign voted_target = (target_copy[2] & target_copy[1])
                        | (target_copy[2] & target_copy[0])
                        | (target_copy[1] & target_copy[0]);

    // Lines are read in pairs so each interleaved frame keeps whole Bayer rows
    // An even target takes its partner line next, an odd one jumps ahead
    // When the jump leaves the frame, the cut-off half pair from an earlier
    // interleaved frame is filled in instead
    always_comb begin
        if (!voted_target[0]) begin
            next_target = voted_target + count_t'(1);
        end else if (voted_target < count_t'(lines_in_frame - interleave_jump_size)) begin
            next_target = voted_target + count_t'(interleave_jump_size);
        end else begin
            next_target = voted_target
                        + count_t'(interleave_jump_size - n_interleaved_frames + 1);
        end
    end

    // Each interleaved frame starts two lines further down than the last one
    assign restart_target = count_t'(frame_idx + 1'b1) << 1;

    // The kept line has just been counted past
    assign target_done = pos.line_advanced && (pos.prev_line_in_frame == voted_target);

    always_ff @(posedge clk) begin
        if (!rst_n || !streaming) begin
            // Everything restarts before each capture
            all_frames_done <= 1'b0;
            line_in_iframe <= '0;
            frame_idx <= '0;
            for (int i = 0; i < 3; i++) begin
                target_copy[i] <= '0;
            end
        end else if (target_done) begin
            if (line_in_iframe >= count_t'(interleaved_lines_per_frame - 1)) begin
                line_in_iframe <= '0;
                if (frame_idx >= frame_idx_t'(n_interleaved_frames - 1)) begin
                    all_frames_done <= 1'b1;
                end else begin
                    frame_idx <= frame_idx + frame_idx_t'(1);
                    for (int i = 0; i < 3; i++) begin
                        target_copy[i] <= restart_target;
                    end
                end
            end else begin
                line_in_iframe <= line_in_iframe + count_t'(1);
                for (int i = 0; i < 3; i++) begin
                    target_copy[i] <= next_target;
                end
            end
        end else if (voted_target >= count_t'(lines_in_frame)) begin
            // A target past the frame would never match, so the image ends
            // early instead of hanging
            all_frames_done <= 1'b1;
        end
    end

    // Write enable for the FIFO, qualified by the sample strobe downstream
    assign keep_pixel = pos.line_active
                      && (pos.line_in_frame == voted_target)
                      && streaming;

endmodule

// File: hw/line_tracker.sv
`timescale 1ns/1ns

module line_tracker (
    input logic clk,
    input logic rst_n,
    input cam_pkg::cam_bus_t filtered,
    input cam_pkg::cam_events_t events,
    output cam_pkg::line_pos_t pos
);

    import cam_pkg::*;

    // ************************************************************************
    // Line state and pixel counter
    // ************************************************************************

    // High while the pixel data belongs to a line
    logic line_active;
    // Set after a full line so that a line valid still high cannot start a
    // second line
    logic waiting_for_line_end;
    // Pixels sampled so far in this line
    // Before and during the strobe it is the column being sampled
    count_t pixel_count;
    logic in_blanking;

    // All data bits read zero during any blanking interval
    assign in_blanking = (filtered.pixel == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_active <= 1'b0;
            waiting_for_line_end <= 1'b0;
            pixel_count <= '0;
        end else if (line_active) begin
            // A line only ends once a full line of pixels has been sampled
            // Greater-or-equal lets a corrupted count still end the line
            if (pixel_count >= count_t'(valid_line_size)) begin
                line_active <= 1'b0;
                pixel_count <= '0;
                waiting_for_line_end <= 1'b1;
            end else if (events.sample_strobe) begin
                pixel_count <= pixel_count + count_t'(1);
            end
        end else begin
            // Line valid must be seen low in blanking before a new line can start
            if (!filtered.line_valid && in_blanking) begin
                waiting_for_line_end <= 1'b0;
            end
            if (filtered.line_valid && !waiting_for_line_end) begin
                line_active <= 1'b1;
            end
        end
    end

    // ************************************************************************
    // Line counter
    // ************************************************************************

    // All line counts advance in the blanking that follows a finished line
    count_t line_count;
    // Usually the line before, except at the frame wrap
    count_t prev_line_count;
    // Allows one advance per line
    logic can_advance;
    logic line_advanced;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_count <= '0;
            prev_line_count <= '0;
            can_advance <= 1'b0;
            line_advanced <= 1'b0;
        end else begin
            line_advanced <= 1'b0;

            // Line valid low, line state done and data in blanking together
            // confirm that the line is really over
            if (!filtered.line_valid && !line_active && in_blanking && can_advance) begin
                can_advance <= 1'b0;
                prev_line_count <= line_count;
                line_count <= line_count + count_t'(1);
                line_advanced <= 1'b1;
            end

            // Being back inside a line re-arms the counter
            if (line_active && !can_advance) begin
                can_advance <= 1'b1;
            end

            // The inter-frame gap restarts the count
            // It overrides an advance taken on the same clock
            if (events.out_of_frame && !line_active) begin
                prev_line_count <= line_count;
                line_count <= '0;
            end
        end
    end

    assign pos.line_active = line_active;
    assign pos.pixel_in_line = pixel_count;
    assign pos.line_in_frame = line_count;
    assign pos.prev_line_in_frame = prev_line_count;
    assign pos.line_advanced = line_advanced;

endmodule

// File: hw/cam_input_conditioner.sv
`timescale 1ns/1ns

module cam_input_conditioner (
    input logic clk,
    input cam_pkg::cam_bus_t raw,
    output cam_pkg::cam_bus_t filtered,
    output cam_pkg::cam_events_t events
);

    import cam_pkg::*;

    // ************************************************************************
    // Synchronizer and consensus buffer
    // ************************************************************************

    // The whole bus moves as one word so every bit sees the same latency
    cam_bus_t sync_chain [0:sync_stages];
    // Last three synchronized samples feed the majority vote
    cam_bus_t vote_buf [0:2];
    // Filtered bus one clock late, used for edge detection
    cam_bus_t filtered_prev;
    logic [pix_sample_delay-1:0] strobe_pipe;
    logic pixclk_fell;

    // Every camera signal is asynchronous to clk, so all of them go through
    // the flip-flop chain before anything looks at them
    always_ff @(posedge clk) begin
        sync_chain[0] <= raw;
        for (int i = 1; i <= sync_stages; i++) begin
            sync_chain[i] <= sync_chain[i-1];
        end
    end

    // Three buffered samples give the majority filter its inputs
    // There are only four clocks per pixel-clock half period, so three is the most
    // that still follows the bus
    always_ff @(posedge clk) begin
        vote_buf[0] <= sync_chain[sync_stages];
        vote_buf[1] <= vote_buf[0];
        vote_buf[2] <= vote_buf[1];
    end

    // Two-of-three vote per bit removes any single-clock glitch
    assign filtered = cam_bus_t'((vote_buf[2] & vote_buf[1])
                               | (vote_buf[2] & vote_buf[0])
                               | (vote_buf[1] & vote_buf[0]));

    // ************************************************************************
    // Edge detection and sample strobe
    // ************************************************************************

    always_ff @(posedge clk) begin
        filtered_prev <= filtered;
    end

    // One-clock pulse on the falling edge of the filtered pixel clock
    assign pixclk_fell = filtered_prev.pixclk & ~filtered.pixclk;

    // The sensor changes data on the pixel-clock rise, so sampling a couple
    // of clocks after the fall lands in the middle of a stable pixel
    always_ff @(posedge clk) begin
        strobe_pipe[0] <= pixclk_fell;
        for (int i = 1; i < pix_sample_delay; i++) begin
            strobe_pipe[i] <= strobe_pipe[i-1];
        end
    end

    assign events.pixclk_fell = pixclk_fell;
    assign events.sample_strobe = strobe_pipe[pix_sample_delay-1];

    // Taken only from the inputs, so noisier than the tracked state but
    // certain whenever it is seen
    // Blanking between frames drives all data bits to zero
    assign events.out_of_frame = ~filtered.frame_valid
                               & ~filtered.line_valid
                               & (filtered.pixel == '0);

endmodule

// File: hw/cam_pkg.sv
package cam_pkg;

    // ************************************************************************
    // Bus and counter sizes
    // ************************************************************************
    localparam int pixel_width = 12;
    localparam int fifo_width = 8;
    localparam int count_width = 12;

    // Depth of the flip-flop chain that brings the camera bus into clk
    localparam int sync_stages = 4;
    // Clocks between a filtered pixel-clock fall and the sample strobe
    localparam int pix_sample_delay = 2;

    // Frame geometry, scaled down so a full capture simulates quickly
    localparam int valid_line_size = 8;
    localparam int lines_in_frame = 12;
    localparam int n_interleaved_frames = 4;
    // The mean step over a pair of lines has to equal the interleave count
    localparam int interleave_jump_size = 2 * n_interleaved_frames - 1;
    localparam int interleaved_lines_per_frame = lines_in_frame / n_interleaved_frames;

    // Capture FSM timing in system clocks
    localparam int boot_settle_cycles = 64;
    localparam int state_timeout_cycles = 50000;
    localparam int state_timer_width = $clog2(state_timeout_cycles + 1);

    typedef logic [count_width-1:0] count_t;
    typedef logic [4:0] frame_idx_t;
    typedef logic [state_timer_width-1:0] state_timer_t;

    typedef enum logic [1:0] {
        BOOT,
        IDLE,
        WAIT_FRAME_END,
        STREAMING
    } capture_state_t;

    // Parallel camera bus, used both raw and after filtering
    typedef struct packed {
        logic pixclk;
        logic frame_valid;
        logic line_valid;
        logic [pixel_width-1:0] pixel;
    } cam_bus_t;

    typedef struct packed {
        logic pixclk_fell;
        logic sample_strobe;
        logic out_of_frame;
    } cam_events_t;

    typedef struct packed {
        logic line_active;
        count_t pixel_in_line;
        count_t line_in_frame;
        count_t prev_line_in_frame;
        logic line_advanced;
    } line_pos_t;

endpackage
